// ==== hdl/tmu_mem_pkg.sv ====
////////////////////////////////////////////////////////////
// texel store geometry in byte addresses, line index and beats
// store is 2 KiB, lines are 32 bytes, beats are 64 bits
// beat 0 of a line sits in the top 64 bits of line_t
////////////////////////////////////////////////////////////
`default_nettype none

package tmu_mem_pkg;

	////////////////////////////////////////////////////////////
	// store size
	////////////////////////////////////////////////////////////
	localparam int tex_depth = 11;                  // log2 of capacity in bytes
	typedef logic [tex_depth-1:0] tex_addr_t;       // 16-bit aligned byte address

	////////////////////////////////////////////////////////////
	// memory beats and lines
	////////////////////////////////////////////////////////////
	localparam int beat_w         = 64;             // bits per memory beat
	localparam int beats_per_line = 4;              // beats making up one line
	localparam int line_w         = beat_w * beats_per_line;

	typedef logic [beat_w-1:0]                 beat_t;
	typedef logic [line_w-1:0]                 line_t;
	typedef logic [$clog2(beats_per_line)-1:0] beat_idx_t; // beat slot in a line

	// 32-byte lines, so the low 5 address bits are inside the line
	localparam int line_idx_w = tex_depth - 5;
	typedef logic [line_idx_w-1:0] line_idx_t;

	// each dual-port RAM holds 64-bit words
	localparam int ram_depth = tex_depth - 3;       // log2 of words per RAM

endpackage

`default_nettype wire

// ==== hdl/tmu_pix_pkg.sv ====
////////////////////////////////////////////////////////////
// pixel formats for the blend stage
// texels are RGB565 without alpha
// fractions are 6-bit weights out of 64
////////////////////////////////////////////////////////////
`default_nettype none

package tmu_pix_pkg;

	// RGB565 channel widths with red in the top bits
	localparam int red_w = 5;
	localparam int grn_w = 6;
	localparam int blu_w = 5;

	typedef logic [red_w+grn_w+blu_w-1:0] texel_t;

	////////////////////////////////////////////////////////////
	// blend weights
	////////////////////////////////////////////////////////////
	localparam int frac_w      = 6;
	localparam int frac_one    = 1 << frac_w;      // weight of a full texel (64)
	localparam int blend_shift = 2 * frac_w;       // bits of two weights multiplied (12)

	typedef logic [frac_w-1:0] frac_t;             // weight out of 64
	typedef logic [frac_w:0]   weight_t;           // wide enough for 64 - frac

	// blend arithmetic sized for the widest channel (green)
	typedef logic [grn_w-1:0]          chan_t;
	typedef logic [grn_w+frac_w-1:0]   hsum_t;     // one horizontal weighted sum
	typedef logic [grn_w+2*frac_w-1:0] vsum_t;     // vertical sum before shift

endpackage

`default_nettype wire

// ==== hdl/tmu_tdpram.sv ====
////////////////////////////////////////////////////////////
// true dual-port RAM on one clock without reset
// both ports read every cycle and return data a cycle later
// read during a write on the same port returns old data
// same-address writes on both ports give undefined content
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmu_tdpram #(
	parameter int depth = 8,   // address bits
	parameter int width = 64   // word bits
) (
	input  wire logic             sys_clk,

	// port 1
	input  wire logic [depth-1:0] a,
	input  wire logic             we,
	input  wire logic [width-1:0] di,
	output logic      [width-1:0] do_q,

	// port 2
	input  wire logic [depth-1:0] a2,
	input  wire logic             we2,
	input  wire logic [width-1:0] di2,
	output logic      [width-1:0] do2_q
);

	logic [width-1:0] mem [0:(1<<depth)-1];  // storage array

	always_ff @(posedge sys_clk) begin
		if (we) begin
			mem[a] <= di;                    // port 1 write
		end
		if (we2) begin
			mem[a2] <= di2;                  // port 2 write
		end
		do_q  <= mem[a];                     // registered reads
		do2_q <= mem[a2];
	end

endmodule

`default_nettype wire

// ==== hdl/tmu_qpram.sv ====
////////////////////////////////////////////////////////////
// quad-port texel RAM with four 16-bit reads and one 256-bit write
// read data appears one cycle after the address
// a write takes all four ports and the reads of that cycle are lost
// ports a/b reach only quarters 0/1 of a line, c/d only 2/3
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmu_qpram (
	input  wire logic                   sys_clk,

	input  wire tmu_mem_pkg::tex_addr_t raa,   // 16-bit aligned byte addresses
	input  wire tmu_mem_pkg::tex_addr_t rab,
	input  wire tmu_mem_pkg::tex_addr_t rac,
	input  wire tmu_mem_pkg::tex_addr_t rad,
	output tmu_pix_pkg::texel_t         rda,
	output tmu_pix_pkg::texel_t         rdb,
	output tmu_pix_pkg::texel_t         rdc,
	output tmu_pix_pkg::texel_t         rdd,

	input  wire logic                   we,    // line write strobe
	input  wire tmu_mem_pkg::line_idx_t wa,    // line index
	input  wire tmu_mem_pkg::line_t     wd     // beat 0 on top
);

	import tmu_mem_pkg::*;
	import tmu_pix_pkg::*;

	logic [ram_depth-1:0] ram_a, ram_b, ram_c, ram_d;  // per-port word address
	beat_t                rd64a, rd64b, rd64c, rd64d;  // raw 64-bit read words
	logic [1:0]           lane_a, lane_b, lane_c, lane_d; // texel within word

	// halfword 0 is the most significant one
	function automatic texel_t pick_texel(input beat_t w, input logic [1:0] lane);
		case (lane)
			2'd0:    pick_texel = w[63:48];
			2'd1:    pick_texel = w[47:32];
			2'd2:    pick_texel = w[31:16];
			default: pick_texel = w[15:0];
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// port addressing
	////////////////////////////////////////////////////////////
	// a write puts quarter n of the line on port n at {line, n}
	assign ram_a = we ? {wa, 2'd0} : raa[tex_depth-1:3];
	assign ram_b = we ? {wa, 2'd1} : rab[tex_depth-1:3];
	assign ram_c = we ? {wa, 2'd2} : rac[tex_depth-1:3];
	assign ram_d = we ? {wa, 2'd3} : rad[tex_depth-1:3];

	// lane select follows the RAM read latency
	always_ff @(posedge sys_clk) begin
		lane_a <= raa[2:1];
		lane_b <= rab[2:1];
		lane_c <= rac[2:1];
		lane_d <= rad[2:1];
	end

	always_comb begin
		rda = pick_texel(rd64a, lane_a);
		rdb = pick_texel(rd64b, lane_b);
		rdc = pick_texel(rd64c, lane_c);
		rdd = pick_texel(rd64d, lane_d);
	end

	////////////////////////////////////////////////////////////
	// ram0 holds quarters 0/1 and ram1 quarters 2/3
	////////////////////////////////////////////////////////////
	tmu_tdpram #(
		.depth (ram_depth),
		.width ($bits(beat_t))
	) ram0 (
		.sys_clk (sys_clk),
		.a       (ram_a),
		.we      (we),
		.di      (wd[255:192]),
		.do_q    (rd64a),
		.a2      (ram_b),
		.we2     (we),
		.di2     (wd[191:128]),
		.do2_q   (rd64b)
	);

	tmu_tdpram #(
		.depth (ram_depth),
		.width ($bits(beat_t))
	) ram1 (
		.sys_clk (sys_clk),
		.a       (ram_c),
		.we      (we),
		.di      (wd[127:64]),
		.do_q    (rd64c),
		.a2      (ram_d),
		.we2     (we),
		.di2     (wd[63:0]),
		.do2_q   (rd64d)
	);

endmodule

`default_nettype wire

// ==== hdl/tmu_line_fill.sv ====
////////////////////////////////////////////////////////////
// collects four 64-bit beats into one 256-bit line
// fill_start is taken only when idle, beats only while busy
// line_we pulses one cycle after the fourth beat
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmu_line_fill (
	input  wire logic                   sys_clk,
	input  wire logic                   arst_n,

	input  wire logic                   fill_start, // begin a fill
	input  wire tmu_mem_pkg::line_idx_t fill_line,  // target line sampled with start
	input  wire logic                   fill_beat,  // one beat strobe
	input  wire tmu_mem_pkg::beat_t     fill_data,
	output logic                        fill_busy,

	output logic                        line_we,    // single-cycle line write
	output tmu_mem_pkg::line_idx_t      line_idx,
	output tmu_mem_pkg::line_t          line_data
);

	import tmu_mem_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_collect,
		st_write
	} fill_state_t;

	fill_state_t state;
	beat_idx_t   beat_cnt;   // beats received so far
	beat_idx_t   slot;       // line quarter for the current beat
	line_t       line_q;     // line under assembly
	line_idx_t   idx_q;

	assign slot = beat_idx_t'(beats_per_line - 1) - beat_cnt;  // first beat on top

	////////////////////////////////////////////////////////////
	// control
	////////////////////////////////////////////////////////////
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= st_idle;
			beat_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (fill_start) begin
						state    <= st_collect;
						beat_cnt <= '0;
					end
				end
				st_collect: begin
					if (fill_beat) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (beat_cnt == beat_idx_t'(beats_per_line - 1)) begin
							state <= st_write;   // last beat in
						end
					end
				end
				st_write: state <= st_idle;  // one write cycle only
				default:  state <= st_idle;
			endcase
		end
	end

	// line buffer and index
	always_ff @(posedge sys_clk) begin
		if (state == st_idle && fill_start) begin
			idx_q <= fill_line;
		end
		if (state == st_collect && fill_beat) begin
			line_q[slot*beat_w +: beat_w] <= fill_data;
		end
	end

	assign fill_busy = (state != st_idle);
	assign line_we   = (state == st_write);
	assign line_idx  = idx_q;
	assign line_data = line_q;

endmodule

`default_nettype wire

// ==== hdl/tmu_bilinear.sv ====
////////////////////////////////////////////////////////////
// per-channel bilinear blend of four RGB565 texels
// texels arrive one cycle after req_valid
// horizontal sums register at req+2 and pix_rgb/pix_valid at req+3
// results are truncated without rounding
// fully pipelined for a request every cycle without stall
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmu_bilinear (
	input  wire logic                sys_clk,
	input  wire logic                arst_n,

	input  wire logic                req_valid,
	input  wire tmu_pix_pkg::frac_t  frac_x,   // weight of b and d
	input  wire tmu_pix_pkg::frac_t  frac_y,   // weight of the bottom row

	input  wire tmu_pix_pkg::texel_t tex_a,    // top left
	input  wire tmu_pix_pkg::texel_t tex_b,    // top right
	input  wire tmu_pix_pkg::texel_t tex_c,    // bottom left
	input  wire tmu_pix_pkg::texel_t tex_d,    // bottom right

	output logic                     pix_valid,
	output tmu_pix_pkg::texel_t      pix_rgb
);

	import tmu_pix_pkg::*;

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////
	// channel fields zero extended to the widest channel
	function automatic chan_t red_of(input texel_t t);
		red_of = chan_t'(t[red_w+grn_w+blu_w-1:grn_w+blu_w]);
	endfunction

	function automatic chan_t grn_of(input texel_t t);
		grn_of = chan_t'(t[grn_w+blu_w-1:blu_w]);
	endfunction

	function automatic chan_t blu_of(input texel_t t);
		blu_of = chan_t'(t[blu_w-1:0]);
	endfunction

	// p*(64-f) + q*f fits since the weights add up to 64
	function automatic hsum_t hmix(input chan_t p, input chan_t q, input frac_t f);
		weight_t wq;
		weight_t wp;
		wq   = weight_t'(f);
		wp   = weight_t'(frac_one) - wq;
		hmix = hsum_t'(p) * hsum_t'(wp) + hsum_t'(q) * hsum_t'(wq);
	endfunction

	// second weighting and the shift back to channel range
	function automatic chan_t vmix(input hsum_t t, input hsum_t b, input frac_t f);
		weight_t wb;
		weight_t wt;
		vsum_t   s;
		wb   = weight_t'(f);
		wt   = weight_t'(frac_one) - wb;
		s    = vsum_t'(t) * vsum_t'(wt) + vsum_t'(b) * vsum_t'(wb);
		vmix = chan_t'(s >> blend_shift);
	endfunction

	////////////////////////////////////////////////////////////
	// stage 0 lines up the request side with the RAM output
	////////////////////////////////////////////////////////////
	logic  valid_0;
	frac_t fx_0, fy_0;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_0 <= 1'b0;
		end else begin
			valid_0 <= req_valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		fx_0 <= frac_x;
		fy_0 <= frac_y;
	end

	////////////////////////////////////////////////////////////
	// stage 1 blends the top and bottom rows horizontally
	////////////////////////////////////////////////////////////
	logic  valid_1;
	frac_t fy_1;
	hsum_t top_r, top_g, top_b;
	hsum_t bot_r, bot_g, bot_b;

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_1 <= 1'b0;
		end else begin
			valid_1 <= valid_0;
		end
	end

	always_ff @(posedge sys_clk) begin
		fy_1  <= fy_0;
		top_r <= hmix(red_of(tex_a), red_of(tex_b), fx_0);
		top_g <= hmix(grn_of(tex_a), grn_of(tex_b), fx_0);
		top_b <= hmix(blu_of(tex_a), blu_of(tex_b), fx_0);
		bot_r <= hmix(red_of(tex_c), red_of(tex_d), fx_0);
		bot_g <= hmix(grn_of(tex_c), grn_of(tex_d), fx_0);
		bot_b <= hmix(blu_of(tex_c), blu_of(tex_d), fx_0);
	end

	////////////////////////////////////////////////////////////
	// stage 2 blends vertically into the output register
	////////////////////////////////////////////////////////////
	chan_t mix_r, mix_g, mix_b;

	always_comb begin
		mix_r = vmix(top_r, bot_r, fy_1);
		mix_g = vmix(top_g, bot_g, fy_1);
		mix_b = vmix(top_b, bot_b, fy_1);
	end

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			pix_valid <= 1'b0;
			pix_rgb   <= '0;
		end else begin
			pix_valid <= valid_1;
			if (valid_1) begin
				pix_rgb <= {mix_r[red_w-1:0], mix_g, mix_b[blu_w-1:0]}; // held between results
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tmu_texel_unit.sv ====
////////////////////////////////////////////////////////////
// texel unit top with line fill, quad-port store and bilinear blend
// requests are only valid while fill_busy is low
// a line write overrides any read in its cycle
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmu_texel_unit (
	input  wire logic                   sys_clk,
	input  wire logic                   arst_n,

	// fill side
	input  wire logic                   fill_start,
	input  wire tmu_mem_pkg::line_idx_t fill_line,
	input  wire logic                   fill_beat,
	input  wire tmu_mem_pkg::beat_t     fill_data,
	output logic                        fill_busy,

	// read side
	input  wire logic                   req_valid,
	input  wire tmu_mem_pkg::tex_addr_t addr_a,
	input  wire tmu_mem_pkg::tex_addr_t addr_b,
	input  wire tmu_mem_pkg::tex_addr_t addr_c,
	input  wire tmu_mem_pkg::tex_addr_t addr_d,
	input  wire tmu_pix_pkg::frac_t     frac_x,
	input  wire tmu_pix_pkg::frac_t     frac_y,
	output logic                        pix_valid,
	output tmu_pix_pkg::texel_t         pix_rgb
);

	import tmu_mem_pkg::*;
	import tmu_pix_pkg::*;

	logic      line_we;                       // fill -> RAM
	line_idx_t line_idx;
	line_t     line_data;
	texel_t    tex_a, tex_b, tex_c, tex_d;    // RAM -> blend at req+1

	tmu_line_fill u_fill (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.fill_start (fill_start),
		.fill_line  (fill_line),
		.fill_beat  (fill_beat),
		.fill_data  (fill_data),
		.fill_busy  (fill_busy),
		.line_we    (line_we),
		.line_idx   (line_idx),
		.line_data  (line_data)
	);

	tmu_qpram u_ram (
		.sys_clk (sys_clk),
		.raa     (addr_a),
		.rab     (addr_b),
		.rac     (addr_c),
		.rad     (addr_d),
		.rda     (tex_a),
		.rdb     (tex_b),
		.rdc     (tex_c),
		.rdd     (tex_d),
		.we      (line_we),
		.wa      (line_idx),
		.wd      (line_data)
	);

	tmu_bilinear u_blend (
		.sys_clk   (sys_clk),
		.arst_n    (arst_n),
		.req_valid (req_valid),
		.frac_x    (frac_x),
		.frac_y    (frac_y),
		.tex_a     (tex_a),
		.tex_b     (tex_b),
		.tex_c     (tex_c),
		.tex_d     (tex_d),
		.pix_valid (pix_valid),
		.pix_rgb   (pix_rgb)
	);

endmodule

`default_nettype wire

// ==== dv/tmu_texel_unit_tb.sv ====
////////////////////////////////////////////////////////////
// directed testbench for the texel unit
// ports a/b only reach line quarters 0/1 (ram0), c/d 2/3,
// so every random address respects that split
// a shadow memory and a blend model give expected pixels
////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tmu_texel_unit_tb;

	import tmu_mem_pkg::*;
	import tmu_pix_pkg::*;

	// cycle budget of reset, two fills, 64 fills, 1024 reads, corners, stream and overwrite
	localparam int est_cycles     = 8 + 2 * 30 + 64 * 14 + 1027 + 4 * 4 + 53 + 30 + 51;
	localparam int timeout_cycles = 3 * est_cycles;

	logic      sys_clk = 1'b0;
	logic      arst_n;
	logic      fill_start, fill_beat, fill_busy;
	line_idx_t fill_line;
	beat_t     fill_data;
	logic      req_valid, pix_valid;
	tex_addr_t addr_a, addr_b, addr_c, addr_d;
	frac_t     frac_x, frac_y;
	texel_t    pix_rgb;

	string     test_name = "none";
	int        tick      = 0;     // negedges seen by the main flow
	int        cycles    = 0;     // free running cycle count for the timeout
	beat_t     shadow [0:255];    // store model indexed by {line, quarter}
	texel_t    exp_q [$];         // expected pixels in issue order
	int        due_q [$];         // tick at which each one is due

	tmu_texel_unit dut (
		.sys_clk    (sys_clk),
		.arst_n     (arst_n),
		.fill_start (fill_start),
		.fill_line  (fill_line),
		.fill_beat  (fill_beat),
		.fill_data  (fill_data),
		.fill_busy  (fill_busy),
		.req_valid  (req_valid),
		.addr_a     (addr_a),
		.addr_b     (addr_b),
		.addr_c     (addr_c),
		.addr_d     (addr_d),
		.frac_x     (frac_x),
		.frac_y     (frac_y),
		.pix_valid  (pix_valid),
		.pix_rgb    (pix_rgb)
	);

	always #5 sys_clk = ~sys_clk;     // 10 ns period

	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) fail_now("timeout, the run took too many cycles");
	end

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////
	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic check_value(input string label, input logic [63:0] expected,
	                           input logic [63:0] actual);
		if (actual !== expected) begin
			fail_now($sformatf("error [%s] %s: expected %h, actual %h",
			                   test_name, label, expected, actual));
		end
	endtask

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////
	function automatic int blend_chan(input int pa, pb, pc, pd, fx, fy);
		int top;
		int bot;
		top = pa * (64 - fx) + pb * fx;      // horizontal blend of the top row
		bot = pc * (64 - fx) + pd * fx;
		return (top * (64 - fy) + bot * fy) >> 12;
	endfunction

	function automatic texel_t blend_model(input texel_t ta, tb, tc, td, input int fx, fy);
		int r;
		int g;
		int b;
		r = blend_chan(int'(ta[15:11]), int'(tb[15:11]),
		               int'(tc[15:11]), int'(td[15:11]), fx, fy);
		g = blend_chan(int'(ta[10:5]), int'(tb[10:5]),
		               int'(tc[10:5]), int'(td[10:5]), fx, fy);
		b = blend_chan(int'(ta[4:0]), int'(tb[4:0]),
		               int'(tc[4:0]), int'(td[4:0]), fx, fy);
		return {r[4:0], g[5:0], b[4:0]};
	endfunction

	// highest halfword of a beat is texel 0
	function automatic texel_t texel_at(input tex_addr_t addr);
		beat_t word;
		int    lane;
		word = shadow[addr[10:3]];
		lane = int'(addr[2:1]);
		return word[63 - 16 * lane -: 16];
	endfunction

	function automatic texel_t model_for(input tex_addr_t a, b, c, d, input frac_t fx, fy);
		return blend_model(texel_at(a), texel_at(b), texel_at(c), texel_at(d),
		                   int'(fx), int'(fy));
	endfunction

	function automatic tex_addr_t addr_of(input line_idx_t line, input logic [1:0] quarter,
	                                      input logic [1:0] lane);
		return {line, quarter, lane, 1'b0};
	endfunction

	function automatic tex_addr_t rand_addr(input logic upper);   // upper selects quarters 2/3
		return addr_of(6'($urandom), {upper, 1'($urandom)}, 2'($urandom));
	endfunction

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////
	// advances one clock, drops the strobes and checks any due pixel
	task automatic next_cycle();
		@(negedge sys_clk);
		tick       = tick + 1;
		req_valid  = 1'b0;
		fill_start = 1'b0;
		fill_beat  = 1'b0;
		if (due_q.size() > 0 && due_q[0] == tick) begin
			if (!pix_valid) begin
				fail_now($sformatf("pix_valid missing three cycles after a request in %s",
				                   test_name));
			end else begin
				check_value("pix_rgb", 64'(exp_q[0]), 64'(pix_rgb));
				void'(exp_q.pop_front());
				void'(due_q.pop_front());
			end
		end else if (pix_valid) begin
			fail_now($sformatf("pix_valid high with no request due in %s", test_name));
		end
	endtask

	task automatic issue_req(input tex_addr_t a, b, c, d, input frac_t fx, fy,
	                         input texel_t expected);
		req_valid = 1'b1;
		addr_a    = a;
		addr_b    = b;
		addr_c    = c;
		addr_d    = d;
		frac_x    = fx;
		frac_y    = fy;
		exp_q.push_back(expected);
		due_q.push_back(tick + 3);       // result at request plus 3
	endtask

	task automatic drain();
		while (due_q.size() > 0) next_cycle();
	endtask

	// one line fill with random beats and gaps and checked busy timing
	task automatic fill_line_with(input line_idx_t line, input int max_gap,
	                              input logic inject, input line_idx_t other);
		line_t data;
		int    gap;
		data = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
		check_value("fill_busy before start", 64'(0), 64'(fill_busy));
		fill_start = 1'b1;
		fill_line  = line;
		next_cycle();
		check_value("fill_busy after start", 64'(1), 64'(fill_busy));
		for (int k = 0; k < 4; k++) begin
			gap = int'($urandom_range(max_gap, 0));
			repeat (gap) next_cycle();
			fill_beat = 1'b1;
			fill_data = data[255 - 64 * k -: 64];   // beat 0 on top
			if (inject && k == 1) begin
				fill_start = 1'b1;                  // must be ignored while busy
				fill_line  = other;
			end
			next_cycle();
			check_value("fill_busy during fill", 64'(1), 64'(fill_busy));
		end
		next_cycle();                               // write cycle done
		check_value("fill_busy after write", 64'(0), 64'(fill_busy));
		for (int k = 0; k < 4; k++) shadow[{line, 2'(k)}] = data[255 - 64 * k -: 64];
	endtask

	// lower quarters through port a alone, upper ones through c and d
	task automatic read_back_range(input int first, input int count);
		tex_addr_t addr;
		tex_addr_t other;
		for (int t = first; t < first + count; t++) begin
			addr = 11'(t * 2);
			if (!addr[4]) begin
				other = addr | 11'h010;
				issue_req(addr, addr, other, other, 6'd0, 6'd0, texel_at(addr));
			end else begin
				other = addr & ~11'h010;
				issue_req(other, other, addr, addr, 6'd0, 6'd63,
				          model_for(other, other, addr, addr, 6'd0, 6'd63));
			end
			next_cycle();
		end
		drain();
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////
	task automatic test_reset();
		test_name = "reset";
		check_value("fill_busy", 64'(0), 64'(fill_busy));
		check_value("pix_valid", 64'(0), 64'(pix_valid));
		check_value("pix_rgb", 64'(0), 64'(pix_rgb));
	endtask

	task automatic test_fill_timing();
		test_name = "fill_timing";
		fill_beat = 1'b1;                          // stray beat while idle
		fill_data = '1;
		next_cycle();
		check_value("fill_busy after stray beat", 64'(0), 64'(fill_busy));
		fill_line_with(6'd5, 3, 1'b1, 6'd9);
		read_back_range(5 * 16, 16);
	endtask

	task automatic test_read_back();
		test_name = "read_back";
		for (int l = 0; l < 64; l++) fill_line_with(6'(l), 1, 1'b0, 6'd0);
		read_back_range(0, 1024);
	endtask

	task automatic test_corners();
		tex_addr_t a, b, c, d;
		frac_t     fxs [4];
		frac_t     fys [4];
		test_name = "corners";
		fxs = '{6'd0, 6'd63, 6'd0, 6'd63};
		fys = '{6'd0, 6'd0, 6'd63, 6'd63};
		a = addr_of(6'($urandom), 2'd0, 2'($urandom));  // four distinct quarters
		b = addr_of(6'($urandom), 2'd1, 2'($urandom));
		c = addr_of(6'($urandom), 2'd2, 2'($urandom));
		d = addr_of(6'($urandom), 2'd3, 2'($urandom));
		for (int i = 0; i < 4; i++) begin
			issue_req(a, b, c, d, fxs[i], fys[i], model_for(a, b, c, d, fxs[i], fys[i]));
			next_cycle();
			drain();
		end
	endtask

	task automatic test_random_blends();
		tex_addr_t a, b, c, d;
		frac_t     fx, fy;
		test_name = "random_blends";
		repeat (50) begin
			a  = rand_addr(1'b0);
			b  = rand_addr(1'b0);
			c  = rand_addr(1'b1);
			d  = rand_addr(1'b1);
			fx = 6'($urandom);
			fy = 6'($urandom);
			issue_req(a, b, c, d, fx, fy, model_for(a, b, c, d, fx, fy));
			next_cycle();                          // back to back at one per cycle
		end
		drain();
	endtask

	task automatic test_overwrite();
		test_name = "overwrite";
		fill_line_with(6'd20, 2, 1'b0, 6'd0);
		read_back_range(19 * 16, 48);              // new line plus both neighbors
	endtask

	initial begin
		arst_n     = 1'b0;
		fill_start = 1'b0;
		fill_line  = '0;
		fill_beat  = 1'b0;
		fill_data  = '0;
		req_valid  = 1'b0;
		addr_a     = '0;
		addr_b     = '0;
		addr_c     = '0;
		addr_d     = '0;
		frac_x     = '0;
		frac_y     = '0;
		void'($urandom(3));
		repeat (8) @(negedge sys_clk);
		arst_n = 1'b1;
		test_reset();
		test_fill_timing();
		test_read_back();
		test_corners();
		test_random_blends();
		test_overwrite();
		$display("All tests passed!");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/tmu_mem_pkg.sv
hdl/tmu_pix_pkg.sv
hdl/tmu_tdpram.sv
hdl/tmu_qpram.sv
hdl/tmu_line_fill.sv
hdl/tmu_bilinear.sv
hdl/tmu_texel_unit.sv
dv/tmu_texel_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the texel unit testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module tmu_texel_unit_tb \
	-f flist.f \
	-o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "build failed"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0
